// File: ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// instruction field widths
`define CTRL_OPCODE_W 6
`define CTRL_FUNCT_W 6

// busy cycles of the iterative multiplier and divider
`define CTRL_MULDIV_CYCLES 33

// counter width, must hold CTRL_MULDIV_CYCLES - 1
`define CTRL_COUNT_W 6

`endif

// File: ctrl_pkg.sv
`default_nettype none

`include "ctrl_config.svh"

package ctrlPkg;

    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        opRType = 6'h00, // decoded further by funct
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opLui   = 6'h0f,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        fnSll   = 6'h00,
        fnSrl   = 6'h02,
        fnSra   = 6'h03,
        fnSllv  = 6'h04,
        fnSrav  = 6'h07,
        fnJr    = 6'h08,
        fnBreak = 6'h0d,
        fnMfhi  = 6'h10,
        fnMflo  = 6'h12,
        fnMult  = 6'h18,
        fnDiv   = 6'h1a,
        fnAdd   = 6'h20,
        fnSub   = 6'h22,
        fnAnd   = 6'h24,
        fnSlt   = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsShiftImm, clsShiftReg, clsLoad, clsStore, clsBranch,
        clsJump, clsJumpLink, clsJumpReg, clsLoadUpper, clsMoveHi, clsMoveLo,
        clsMulDiv, clsHalt
    } instrClass_t;

    typedef enum logic [2:0] {
        aluPass    = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluAnd     = 3'd3,
        aluCompare = 3'd7 // sets gt/lt/et
    } aluOp_t;

    typedef enum logic [2:0] {
        shHold       = 3'd0,
        shLoad       = 3'd1,
        shLeft       = 3'd2,
        shRightLogic = 3'd3,
        shRightArith = 3'd4
    } shiftOp_t;

    typedef enum logic [1:0] {brEq, brNe, brGt, brLe} branchCond_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        shiftOp_t    shiftOp;
        branchCond_t cond;
        logic        isDiv; // div, else mult
    } instrInfo_t;

    typedef enum logic [4:0] {
        stReset, stFetch, stMemWait, stInstWrite, stDecode,
        stAluExec, stAluToReg, stShiftLoad, stShiftExec, stShiftToReg,
        stMemAddr, stMemRead, stMemReadWait, stMemDataWrite, stMemToReg, stMemWrite,
        stJump, stJumpLink, stJumpReg, stLoadUpper, stMoveHi, stMoveLo,
        stCompare, stBranchTaken, stMulDiv, stWriteHiLo, stHalt
    } ctrlState_t;

    typedef struct packed {
        logic gt;
        logic lt;
        logic et;
    } aluFlags_t;

    typedef struct packed {
        logic pcWrite;
        logic memWrite;
        logic irWrite;
        logic regWrite;
        logic multStart;
        logic divStart;
        logic aluOutWrite;
        logic aWrite;
        logic bWrite;
        logic hiWrite;
        logic loWrite;
        logic memDataWrite;
    } writeStrobes_t;

    typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcBranchOffset} aluSrcB_t;
    typedef enum logic [1:0] {dstRt = 2'd0, dstRd = 2'd1, dstRa = 2'd3} regDst_t;
    typedef enum logic [2:0] {pcAluResult, pcAluOut, pcJumpTarget} pcSrc_t;

    typedef enum logic [3:0] {
        rdMemory   = 4'd1,
        rdAluOut   = 4'd2,
        rdHi       = 4'd3,
        rdLo       = 4'd4,
        rdShifter  = 4'd5,
        rdUpperImm = 4'd8
    } regData_t;

    typedef struct packed {
        logic     iorD;     // memory address from aluOut
        logic     aluSrcA;  // register A, else pc
        logic     shamtSrc; // shift amount from register
        logic     shiftData; // shift source is B, else A
        logic     aluToReg; // slt result into aluOut
        logic     hiLoSrc;  // divider, else multiplier
        aluSrcB_t aluSrcB;
        regDst_t  regDst;
        pcSrc_t   pcSrc;
        regData_t regData;
    } muxSelects_t;

endpackage

`default_nettype wire

// File: instr_decode.sv
`default_nettype none

`include "ctrl_config.svh"

module instr_decode (
    input  wire logic [`CTRL_OPCODE_W-1:0] opcode,
    input  wire logic [`CTRL_FUNCT_W-1:0]  funct,
    output ctrlPkg::instrInfo_t            info
);

    ctrlPkg::opcode_t op;
    ctrlPkg::funct_t  fn;

    assign op = ctrlPkg::opcode_t'(opcode);
    assign fn = ctrlPkg::funct_t'(funct);

    always_comb begin
        info.instrClass = ctrlPkg::clsHalt; // unknown codes stop the unit
        info.aluOp = ctrlPkg::aluPass;
        info.shiftOp = ctrlPkg::shHold;
        info.cond = ctrlPkg::brEq;
        info.isDiv = 1'b0;
        if (op == ctrlPkg::opRType) begin
            case (fn)
                ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra:
                    info.instrClass = ctrlPkg::clsShiftImm;
                ctrlPkg::fnSllv, ctrlPkg::fnSrav: info.instrClass = ctrlPkg::clsShiftReg;
                ctrlPkg::fnJr:    info.instrClass = ctrlPkg::clsJumpReg;
                ctrlPkg::fnMfhi:  info.instrClass = ctrlPkg::clsMoveHi;
                ctrlPkg::fnMflo:  info.instrClass = ctrlPkg::clsMoveLo;
                ctrlPkg::fnMult, ctrlPkg::fnDiv: info.instrClass = ctrlPkg::clsMulDiv;
                ctrlPkg::fnAdd, ctrlPkg::fnSub, ctrlPkg::fnAnd, ctrlPkg::fnSlt:
                    info.instrClass = ctrlPkg::clsAluReg;
                default:          info.instrClass = ctrlPkg::clsHalt; // break and unknown funct
            endcase
            case (fn)
                ctrlPkg::fnAdd: info.aluOp = ctrlPkg::aluAdd;
                ctrlPkg::fnSub: info.aluOp = ctrlPkg::aluSub;
                ctrlPkg::fnAnd: info.aluOp = ctrlPkg::aluAnd;
                ctrlPkg::fnSlt: info.aluOp = ctrlPkg::aluCompare;
                default:        info.aluOp = ctrlPkg::aluPass;
            endcase
            case (fn)
                ctrlPkg::fnSll, ctrlPkg::fnSllv: info.shiftOp = ctrlPkg::shLeft;
                ctrlPkg::fnSrl:                  info.shiftOp = ctrlPkg::shRightLogic;
                ctrlPkg::fnSra, ctrlPkg::fnSrav: info.shiftOp = ctrlPkg::shRightArith;
                default:                         info.shiftOp = ctrlPkg::shHold;
            endcase
            info.isDiv = (fn == ctrlPkg::fnDiv);
        end else begin
            case (op)
                ctrlPkg::opJ:   info.instrClass = ctrlPkg::clsJump;
                ctrlPkg::opJal: info.instrClass = ctrlPkg::clsJumpLink;
                ctrlPkg::opBeq, ctrlPkg::opBne, ctrlPkg::opBle, ctrlPkg::opBgt:
                    info.instrClass = ctrlPkg::clsBranch;
                ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti:
                    info.instrClass = ctrlPkg::clsAluImm;
                ctrlPkg::opLui: info.instrClass = ctrlPkg::clsLoadUpper;
                ctrlPkg::opLw:  info.instrClass = ctrlPkg::clsLoad;
                ctrlPkg::opSw:  info.instrClass = ctrlPkg::clsStore;
                default:        info.instrClass = ctrlPkg::clsHalt;
            endcase
            case (op)
                ctrlPkg::opAddi, ctrlPkg::opAddiu: info.aluOp = ctrlPkg::aluAdd;
                ctrlPkg::opSlti:                   info.aluOp = ctrlPkg::aluCompare;
                ctrlPkg::opLw, ctrlPkg::opSw:      info.aluOp = ctrlPkg::aluAdd; // address
                default:                           info.aluOp = ctrlPkg::aluPass;
            endcase
            case (op)
                ctrlPkg::opBne: info.cond = ctrlPkg::brNe;
                ctrlPkg::opBgt: info.cond = ctrlPkg::brGt;
                ctrlPkg::opBle: info.cond = ctrlPkg::brLe;
                default:        info.cond = ctrlPkg::brEq;
            endcase
        end
    end

    // arithmetic classes must always give the ALU real work
    always_comb begin
        if (info.instrClass == ctrlPkg::clsAluReg || info.instrClass == ctrlPkg::clsAluImm) begin
            assert (info.aluOp != ctrlPkg::aluPass)
                else $error("alu class decoded with pass operation");
        end
    end

endmodule

`default_nettype wire

// File: state_sequencer.sv
`default_nettype none

`include "ctrl_config.svh"

module state_sequencer (
    input  wire logic                clock,
    input  wire logic                RESET_in,
    input  wire ctrlPkg::instrInfo_t info,
    input  wire ctrlPkg::aluFlags_t  flags,
    output ctrlPkg::ctrlState_t      state
);

    localparam logic [`CTRL_COUNT_W-1:0] CountLast = `CTRL_COUNT_W'(`CTRL_MULDIV_CYCLES - 1);

    ctrlPkg::ctrlState_t      nextState;
    logic [`CTRL_COUNT_W-1:0] count; // busy cycles of mult/div
    logic                     countDone;
    logic                     branchTaken;

    assign countDone = (count == CountLast);

    always_comb begin
        case (info.cond)
            ctrlPkg::brEq: branchTaken = flags.et;
            ctrlPkg::brNe: branchTaken = !flags.et;
            ctrlPkg::brGt: branchTaken = flags.gt;
            default:       branchTaken = flags.lt; // ble
        endcase
    end

    always_comb begin
        nextState = ctrlPkg::stFetch; // most tails end here
        case (state)
            ctrlPkg::stReset:     nextState = ctrlPkg::stFetch;
            ctrlPkg::stFetch:     nextState = ctrlPkg::stMemWait;
            ctrlPkg::stMemWait:   nextState = ctrlPkg::stInstWrite;
            ctrlPkg::stInstWrite: nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode: begin
                case (info.instrClass)
                    ctrlPkg::clsAluReg, ctrlPkg::clsAluImm: nextState = ctrlPkg::stAluExec;
                    ctrlPkg::clsShiftImm, ctrlPkg::clsShiftReg:
                        nextState = ctrlPkg::stShiftLoad;
                    ctrlPkg::clsLoad, ctrlPkg::clsStore: nextState = ctrlPkg::stMemAddr;
                    ctrlPkg::clsBranch:    nextState = ctrlPkg::stCompare;
                    ctrlPkg::clsJump:      nextState = ctrlPkg::stJump;
                    ctrlPkg::clsJumpLink:  nextState = ctrlPkg::stJumpLink;
                    ctrlPkg::clsJumpReg:   nextState = ctrlPkg::stJumpReg;
                    ctrlPkg::clsLoadUpper: nextState = ctrlPkg::stLoadUpper;
                    ctrlPkg::clsMoveHi:    nextState = ctrlPkg::stMoveHi;
                    ctrlPkg::clsMoveLo:    nextState = ctrlPkg::stMoveLo;
                    ctrlPkg::clsMulDiv:    nextState = ctrlPkg::stMulDiv;
                    default:               nextState = ctrlPkg::stHalt;
                endcase
            end
            ctrlPkg::stAluExec:   nextState = ctrlPkg::stAluToReg;
            ctrlPkg::stShiftLoad: nextState = ctrlPkg::stShiftExec;
            ctrlPkg::stShiftExec: nextState = ctrlPkg::stShiftToReg;
            ctrlPkg::stMemAddr: begin
                if (info.instrClass == ctrlPkg::clsStore) begin
                    nextState = ctrlPkg::stMemWrite;
                end else begin
                    nextState = ctrlPkg::stMemRead;
                end
            end
            ctrlPkg::stMemRead:      nextState = ctrlPkg::stMemReadWait;
            ctrlPkg::stMemReadWait:  nextState = ctrlPkg::stMemDataWrite;
            ctrlPkg::stMemDataWrite: nextState = ctrlPkg::stMemToReg;
            ctrlPkg::stCompare: begin
                if (branchTaken) begin
                    nextState = ctrlPkg::stBranchTaken;
                end else begin
                    nextState = ctrlPkg::stFetch;
                end
            end
            ctrlPkg::stMulDiv: begin
                if (countDone) begin
                    nextState = ctrlPkg::stWriteHiLo;
                end else begin
                    nextState = ctrlPkg::stMulDiv;
                end
            end
            ctrlPkg::stHalt: nextState = ctrlPkg::stHalt; // only reset leaves
            default:         nextState = ctrlPkg::stFetch;
        endcase
    end

    always_ff @(posedge clock or posedge RESET_in) begin
        if (RESET_in) begin
            state <= ctrlPkg::stReset;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clock or posedge RESET_in) begin
        if (RESET_in) begin
            count <= '0;
        end else if (state == ctrlPkg::stWriteHiLo) begin
            count <= '0; // ready for the next mult/div
        end else if (state == ctrlPkg::stMulDiv && !countDone) begin
            count <= count + 1'b1;
        end
    end

    countInRange: assert property (@(posedge clock) disable iff (RESET_in)
        count <= CountLast)
        else $error("mult/div counter past its limit");

    haltHolds: assert property (@(posedge clock) disable iff (RESET_in)
        state == ctrlPkg::stHalt |=> state == ctrlPkg::stHalt)
        else $error("halt left without reset");

endmodule

`default_nettype wire

// File: control_outputs.sv
`default_nettype none

module control_outputs (
    input  wire ctrlPkg::ctrlState_t state,
    input  wire ctrlPkg::instrInfo_t info,
    output ctrlPkg::writeStrobes_t   strobes,
    output ctrlPkg::muxSelects_t     selects,
    output ctrlPkg::aluOp_t          aluOp,
    output ctrlPkg::shiftOp_t        shiftOp,
    output logic                     resetOut,
    output logic                     halted
);

    assign resetOut = (state == ctrlPkg::stReset);
    assign halted = (state == ctrlPkg::stHalt);

    always_comb begin
        strobes = '0;
        selects = '0; // pc into ALU A, regB into ALU B
        selects.regData = ctrlPkg::rdAluOut;
        aluOp = ctrlPkg::aluPass;
        shiftOp = ctrlPkg::shHold;
        case (state)
            ctrlPkg::stFetch, ctrlPkg::stMemWait, ctrlPkg::stInstWrite: begin
                selects.aluSrcB = ctrlPkg::srcFour; // pc + 4 held until written
                aluOp = ctrlPkg::aluAdd;
                strobes.irWrite = (state == ctrlPkg::stInstWrite);
                strobes.pcWrite = (state == ctrlPkg::stInstWrite);
            end
            ctrlPkg::stDecode: begin
                strobes.aWrite = 1'b1;
                strobes.bWrite = 1'b1;
                selects.aluSrcB = ctrlPkg::srcBranchOffset; // branch target ahead of time
                aluOp = ctrlPkg::aluAdd;
                strobes.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAluExec: begin
                selects.aluSrcA = 1'b1;
                selects.aluSrcB = (info.instrClass == ctrlPkg::clsAluImm) ?
                    ctrlPkg::srcImm : ctrlPkg::srcRegB;
                aluOp = info.aluOp;
                selects.aluToReg = (info.aluOp == ctrlPkg::aluCompare); // slt, slti
                strobes.aluOutWrite = 1'b1;
            end
            ctrlPkg::stAluToReg: begin
                selects.regDst = (info.instrClass == ctrlPkg::clsAluImm) ?
                    ctrlPkg::dstRt : ctrlPkg::dstRd;
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stShiftLoad: begin
                selects.shiftData = (info.instrClass == ctrlPkg::clsShiftImm);
                selects.shamtSrc = (info.instrClass == ctrlPkg::clsShiftReg);
                shiftOp = ctrlPkg::shLoad;
            end
            ctrlPkg::stShiftExec: shiftOp = info.shiftOp;
            ctrlPkg::stShiftToReg: begin
                selects.regData = ctrlPkg::rdShifter;
                selects.regDst = ctrlPkg::dstRd;
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stMemAddr: begin
                selects.aluSrcA = 1'b1;
                selects.aluSrcB = ctrlPkg::srcImm; // base + offset
                aluOp = ctrlPkg::aluAdd;
                strobes.aluOutWrite = 1'b1;
                selects.iorD = 1'b1;
            end
            ctrlPkg::stMemRead, ctrlPkg::stMemReadWait: selects.iorD = 1'b1;
            ctrlPkg::stMemDataWrite: begin
                selects.iorD = 1'b1;
                strobes.memDataWrite = 1'b1;
            end
            ctrlPkg::stMemToReg: begin
                selects.regData = ctrlPkg::rdMemory;
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stMemWrite: begin
                selects.iorD = 1'b1;
                strobes.memWrite = 1'b1;
            end
            ctrlPkg::stJump: begin
                selects.pcSrc = ctrlPkg::pcJumpTarget;
                strobes.pcWrite = 1'b1;
            end
            ctrlPkg::stJumpLink: begin
                selects.pcSrc = ctrlPkg::pcJumpTarget;
                strobes.pcWrite = 1'b1;
                selects.regDst = ctrlPkg::dstRa; // link register
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stJumpReg: begin
                selects.aluSrcA = 1'b1; // rs through the ALU
                strobes.pcWrite = 1'b1;
            end
            ctrlPkg::stLoadUpper: begin
                selects.regData = ctrlPkg::rdUpperImm;
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stMoveHi, ctrlPkg::stMoveLo: begin
                selects.regData = (state == ctrlPkg::stMoveHi) ? ctrlPkg::rdHi : ctrlPkg::rdLo;
                selects.regDst = ctrlPkg::dstRd;
                strobes.regWrite = 1'b1;
            end
            ctrlPkg::stCompare: begin
                selects.aluSrcA = 1'b1;
                aluOp = ctrlPkg::aluCompare; // flags sampled by the sequencer
            end
            ctrlPkg::stBranchTaken: begin
                selects.pcSrc = ctrlPkg::pcAluOut; // target from decode
                strobes.pcWrite = 1'b1;
            end
            ctrlPkg::stMulDiv: begin
                strobes.divStart = info.isDiv;
                strobes.multStart = !info.isDiv;
            end
            ctrlPkg::stWriteHiLo: begin
                selects.hiLoSrc = info.isDiv;
                strobes.hiWrite = 1'b1;
                strobes.loWrite = 1'b1;
            end
            default: ; // reset and halt drive nothing
        endcase
    end

    // a register write and a memory write never share a cycle
    always_comb begin
        assert (!(strobes.regWrite && strobes.memWrite))
            else $error("regWrite and memWrite high together");
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`default_nettype none

`include "ctrl_config.svh"

module control_unit (
    input  wire logic                      clock,
    input  wire logic                      RESET_in,
    input  wire logic [`CTRL_OPCODE_W-1:0] opcode,
    input  wire logic [`CTRL_FUNCT_W-1:0]  funct,
    input  wire ctrlPkg::aluFlags_t        flags,
    output wire ctrlPkg::writeStrobes_t    strobes,
    output wire ctrlPkg::muxSelects_t      selects,
    output wire ctrlPkg::aluOp_t           aluOp,
    output wire ctrlPkg::shiftOp_t         shiftOp,
    output wire logic                      resetOut,
    output wire logic                      halted
);

    wire ctrlPkg::instrInfo_t info;  // decoded instruction
    wire ctrlPkg::ctrlState_t state;

    instr_decode instr_decode_i (
        .opcode (opcode),
        .funct  (funct),
        .info   (info)
    );

    state_sequencer state_sequencer_i (
        .clock    (clock),
        .RESET_in (RESET_in),
        .info     (info),
        .flags    (flags),
        .state    (state)
    );

    control_outputs control_outputs_i (
        .state    (state),
        .info     (info),
        .strobes  (strobes),
        .selects  (selects),
        .aluOp    (aluOp),
        .shiftOp  (shiftOp),
        .resetOut (resetOut),
        .halted   (halted)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic resetInit
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock; // 40 ns period
    end

    initial begin
        resetInit = 1'b1;
        repeat (2) @(posedge clock);
        resetInit <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_control_unit.sv
`default_nettype none

module tb_control_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int instrTotal = 400;
    localparam int cycleLimit = instrTotal * 40 + 100;
    localparam logic [2:0] kindAlu = 3'd0, kindShift = 3'd1, kindLoad = 3'd2;
    localparam logic [2:0] kindStore = 3'd3, kindBranch = 3'd4, kindPlain = 3'd5;
    localparam logic [2:0] kindMulDiv = 3'd6, kindHalt = 3'd7;

    typedef struct packed {
        logic [5:0] op;
        logic [5:0] fn;
        logic [2:0] kind;
        int         tail;  // execute cycles after decode
        logic       rw;
        logic [1:0] dst;
        logic [3:0] data;
        logic [2:0] aluOp; // shift kind for shifts
        logic [1:0] srcB;
        logic       slt;
        logic       isDiv;
        logic [1:0] cond;  // eq, ne, gt, le
    } model_t;

    logic clock, resetInit, reapply, RESET_in;
    logic [5:0] opcode, funct;
    ctrlPkg::aluFlags_t flags, pendFlags;
    ctrlPkg::writeStrobes_t strobes;
    ctrlPkg::muxSelects_t selects;
    ctrlPkg::aluOp_t aluOp;
    ctrlPkg::shiftOp_t shiftOp;
    logic resetOut, halted;

    logic [31:0] rngState;
    logic [5:0] pendOp, pendFn;
    model_t cur;
    logic curTaken, active, afterReset, haltSeen;
    logic [2:0] prevAluOp, prevShiftOp;
    logic [1:0] prevSrcB;
    logic prevSlt;
    int cycles, completed, errorCount, gap, haltCycles, resetOutCycles, sinceResetOut;
    int rwCount, memWriteCount, memDataCount, startRun, hiLoCount;

    assign RESET_in = resetInit | reapply;

    tb_clock_gen tb_clock_gen_i (.clock(clock), .resetInit(resetInit));

    control_unit control_unit_i (
        .clock(clock), .RESET_in(RESET_in), .opcode(opcode), .funct(funct), .flags(flags),
        .strobes(strobes), .selects(selects), .aluOp(aluOp), .shiftOp(shiftOp),
        .resetOut(resetOut), .halted(halted)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // op, fn, kind, tail, rw, dst, data, aluOp or shiftOp, srcB, slt, isDiv, cond
    function automatic model_t modelOf(input int idx);
        case (idx)
            0: return '{6'h00, 6'h20, kindAlu, 2, 1'b1, 2'd1, 4'd2, 3'd1, 2'd0, 1'b0, 1'b0, 2'd0};
            1: return '{6'h00, 6'h22, kindAlu, 2, 1'b1, 2'd1, 4'd2, 3'd2, 2'd0, 1'b0, 1'b0, 2'd0};
            2: return '{6'h00, 6'h24, kindAlu, 2, 1'b1, 2'd1, 4'd2, 3'd3, 2'd0, 1'b0, 1'b0, 2'd0};
            3: return '{6'h00, 6'h2a, kindAlu, 2, 1'b1, 2'd1, 4'd2, 3'd7, 2'd0, 1'b1, 1'b0, 2'd0};
            4: return '{6'h08, 6'h00, kindAlu, 2, 1'b1, 2'd0, 4'd2, 3'd1, 2'd2, 1'b0, 1'b0, 2'd0};
            5: return '{6'h09, 6'h00, kindAlu, 2, 1'b1, 2'd0, 4'd2, 3'd1, 2'd2, 1'b0, 1'b0, 2'd0};
            6: return '{6'h0a, 6'h00, kindAlu, 2, 1'b1, 2'd0, 4'd2, 3'd7, 2'd2, 1'b1, 1'b0, 2'd0};
            7: return '{6'h00, 6'h00, kindShift, 3, 1'b1, 2'd1, 4'd5, 3'd2, 2'd0, 1'b0, 1'b0, 2'd0};
            8: return '{6'h00, 6'h02, kindShift, 3, 1'b1, 2'd1, 4'd5, 3'd3, 2'd0, 1'b0, 1'b0, 2'd0};
            9: return '{6'h00, 6'h03, kindShift, 3, 1'b1, 2'd1, 4'd5, 3'd4, 2'd0, 1'b0, 1'b0, 2'd0};
            10: return '{6'h00, 6'h04, kindShift, 3, 1'b1, 2'd1, 4'd5, 3'd2, 2'd0, 1'b0, 1'b0, 2'd0};
            11: return '{6'h00, 6'h07, kindShift, 3, 1'b1, 2'd1, 4'd5, 3'd4, 2'd0, 1'b0, 1'b0, 2'd0};
            12: return '{6'h23, 6'h00, kindLoad, 5, 1'b1, 2'd0, 4'd1, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            13: return '{6'h2b, 6'h00, kindStore, 2, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            14: return '{6'h04, 6'h00, kindBranch, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            15: return '{6'h05, 6'h00, kindBranch, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd1};
            16: return '{6'h06, 6'h00, kindBranch, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd3};
            17: return '{6'h07, 6'h00, kindBranch, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd2};
            18: return '{6'h02, 6'h00, kindPlain, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            19: return '{6'h03, 6'h00, kindPlain, 1, 1'b1, 2'd3, 4'd2, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            20: return '{6'h00, 6'h08, kindPlain, 1, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            21: return '{6'h0f, 6'h00, kindPlain, 1, 1'b1, 2'd0, 4'd8, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            22: return '{6'h00, 6'h10, kindPlain, 1, 1'b1, 2'd1, 4'd3, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            23: return '{6'h00, 6'h12, kindPlain, 1, 1'b1, 2'd1, 4'd4, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            24: return '{6'h00, 6'h18, kindMulDiv, 34, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            25: return '{6'h00, 6'h1a, kindMulDiv, 34, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b1, 2'd0};
            26: return '{6'h00, 6'h0d, kindHalt, 0, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
            default: return '{6'h3f, 6'h00, kindHalt, 0, 1'b0, 2'd0, 4'd0, 3'd0, 2'd0, 1'b0, 1'b0, 2'd0};
        endcase
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expected, actual);
        $display("[ERROR] %s expected %h got %h", name, expected, actual);
        errorCount++;
    endtask

    task automatic reportText(input string what);
        $display("[ERROR] %s", what);
        errorCount++;
    endtask

    task automatic issueNext();
        int idx;
        rngState = xorshift(rngState);
        if (rngState[31:26] < 6'd2) begin
            idx = 26 + int'(rngState[0]); // rare break or unknown code
        end else begin
            idx = int'(rngState[25:0] % 26'd26);
        end
        cur = modelOf(idx);
        rngState = xorshift(rngState);
        pendFlags = rngState[2:0];
        case (cur.cond)
            2'd0: curTaken = pendFlags.et;
            2'd1: curTaken = !pendFlags.et;
            2'd2: curTaken = pendFlags.gt;
            default: curTaken = pendFlags.lt;
        endcase
        if (cur.kind != kindBranch) curTaken = 1'b0;
        pendOp = cur.op;
        pendFn = cur.fn;
        {gap, rwCount, memWriteCount, memDataCount, startRun, hiLoCount} = '0;
        active = 1'b1;
    endtask

    task automatic finalizeInstr();
        int expGap;
        expGap = 4 + cur.tail + (curTaken ? 1 : 0);
        if (gap != expGap) reportValue("irWrite spacing", expGap, gap);
        if (rwCount != int'(cur.rw)) reportValue("regWrite pulses", 32'(cur.rw), rwCount);
        if (memWriteCount != int'(cur.kind == kindStore))
            reportValue("memWrite pulses", 32'(cur.kind == kindStore), memWriteCount);
        if (memDataCount != int'(cur.kind == kindLoad))
            reportValue("memDataWrite pulses", 32'(cur.kind == kindLoad), memDataCount);
        if (cur.kind == kindMulDiv && hiLoCount != 1) reportValue("hi/lo writes", 1, hiLoCount);
        if (cur.kind != kindMulDiv && (startRun != 0 || hiLoCount != 0))
            reportText("multiply or divide strobes outside a multiply or divide");
        completed++;
    endtask

    task automatic finishRun();
        if (completed < instrTotal) reportText("timeout before all instructions completed");
        $display("run finished: %0d instructions, %0d errors", completed, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        rngState = 32'hb572_43ec;
        opcode = 6'h00;
        funct = 6'h20;
        flags = '0;
        reapply = 1'b0;
        {pendOp, pendFn, pendFlags} = {6'h00, 6'h20, 3'b000};
        {curTaken, active, afterReset, haltSeen, prevSlt} = '0;
        {prevAluOp, prevShiftOp, prevSrcB} = '0;
        cur = modelOf(0);
        {cycles, completed, errorCount, gap, haltCycles, resetOutCycles, sinceResetOut} = '0;
        {rwCount, memWriteCount, memDataCount, startRun, hiLoCount} = '0;
    end

    always @(posedge clock) begin
        opcode <= pendOp; // only changes after an irWrite cycle
        funct <= pendFn;
        flags <= pendFlags;
        reapply <= haltSeen && haltCycles >= 2 && haltCycles < 4;
    end

    always @(negedge clock) begin
        cycles++;
        if (cycles >= cycleLimit || completed >= instrTotal) begin
            finishRun();
        end else begin
            if (haltSeen) haltCycles++;
            if (haltSeen && haltCycles > 4 && !RESET_in) begin
                haltSeen = 1'b0;
                haltCycles = 0;
            end
            if (RESET_in) begin
                afterReset = 1'b1;
                resetOutCycles = 0;
                sinceResetOut = 0;
                active = 1'b0;
            end else begin
                gap++;
                if (afterReset && resetOut) begin
                    resetOutCycles++;
                    sinceResetOut = 0;
                    if (strobes != '0) reportValue("strobes", 32'h0, 32'(strobes));
                end else if (afterReset) begin
                    sinceResetOut++;
                end
                if (halted && !haltSeen) begin
                    if (!active || cur.kind != kindHalt)
                        reportText("unit halted on an instruction other than break or unknown");
                    if (gap != 2) reportValue("halt cycle", 2, gap);
                    haltSeen = 1'b1;
                    haltCycles = 0;
                    active = 1'b0;
                    completed++;
                end
                if (active && strobes.regWrite) begin
                    rwCount++;
                    if (selects.regDst != cur.dst)
                        reportValue("regDst", 32'(cur.dst), 32'(selects.regDst));
                    if (selects.regData != cur.data)
                        reportValue("regData", 32'(cur.data), 32'(selects.regData));
                    if (cur.kind == kindAlu && prevAluOp != cur.aluOp)
                        reportValue("aluOp", 32'(cur.aluOp), 32'(prevAluOp));
                    if (cur.kind == kindAlu && prevSrcB != cur.srcB)
                        reportValue("aluSrcB", 32'(cur.srcB), 32'(prevSrcB));
                    if (cur.kind == kindAlu && prevSlt != cur.slt)
                        reportValue("aluToReg", 32'(cur.slt), 32'(prevSlt));
                    if (cur.kind == kindShift && prevShiftOp != cur.aluOp)
                        reportValue("shiftOp", 32'(cur.aluOp), 32'(prevShiftOp));
                    if (cur.kind == kindLoad && memDataCount != 1)
                        reportText("load wrote its register without a memDataWrite first");
                end
                if (active && (strobes.multStart || strobes.divStart)) begin
                    startRun++;
                    if (strobes.divStart != cur.isDiv || strobes.multStart == cur.isDiv)
                        reportValue("divStart", 32'(cur.isDiv), 32'(strobes.divStart));
                end
                if (active && (strobes.hiWrite || strobes.loWrite)) begin
                    hiLoCount++;
                    if (!(strobes.hiWrite && strobes.loWrite))
                        reportText("hiWrite and loWrite did not pulse together");
                    if (startRun != 33) reportValue("mult/div busy cycles", 33, startRun);
                    if (selects.hiLoSrc != cur.isDiv)
                        reportValue("hiLoSrc", 32'(cur.isDiv), 32'(selects.hiLoSrc));
                end
                if (active && strobes.memWrite) begin
                    memWriteCount++;
                    if (!selects.iorD) reportValue("iorD", 32'h1, 32'h0);
                end
                if (active && strobes.memDataWrite) memDataCount++;
                if (strobes.irWrite) begin
                    if (haltSeen) reportText("irWrite while halted");
                    if (afterReset) begin
                        if (resetOutCycles != 1)
                            reportValue("resetOut cycles", 1, resetOutCycles);
                        if (sinceResetOut != 3)
                            reportValue("first irWrite delay", 3, sinceResetOut);
                        afterReset = 1'b0;
                    end else if (active) begin
                        finalizeInstr();
                    end
                    issueNext(); // driven on the edge that ends this cycle
                end
            end
            prevAluOp = aluOp;
            prevShiftOp = shiftOp;
            prevSrcB = selects.aluSrcB;
            prevSlt = selects.aluToReg;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
ctrl_pkg.sv
instr_decode.sv
state_sequencer.sv
control_outputs.sv
control_unit.sv
tb_clock_gen.sv
tb_control_unit.sv

// File: run.sh
#!/usr/bin/env bash
# builds the control unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_control_unit -o tb_control_unit_sim \
    && ./obj_dir/tb_control_unit_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && exit 0 \
    || exit 1
